/* beat_packer.sv */
/*
 * Beat packer
 * Serial-in, parallel-out packing of cache words and their byte
 * strobes into one AXI beat. Slot 0 lands in the low half.
 */

`timescale 1ns/1ps

module beat_packer
  import cache_axi_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  logic [DATA_W-1:0]     word_i,
  input  logic [STRB_W-1:0]     strb_i,
  output logic                  ready_o,
  output logic                  valid_o,
  output logic [AXI_DATA_W-1:0] beat_o,
  output logic [AXI_STRB_W-1:0] beat_strb_o,
  input  logic                  yumi_i
);

  logic [WORDS_PER_BEAT-1:0][DATA_W-1:0] data_r;
  logic [WORDS_PER_BEAT-1:0][STRB_W-1:0] strb_r;
  logic [$clog2(WORDS_PER_BEAT+1)-1:0]   fill_r;
  logic [$clog2(WORDS_PER_BEAT)-1:0]     wr_idx;
  logic                                  accept;

  assign valid_o = (fill_r == WORDS_PER_BEAT);

  // emptying and refilling slot 0 can share a cycle
  assign ready_o = !valid_o || yumi_i;
  assign accept  = valid_i && ready_o;
  assign wr_idx  = yumi_i ? '0 : fill_r[$clog2(WORDS_PER_BEAT)-1:0];

  assign beat_o      = data_r;
  assign beat_strb_o = strb_r;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_r[wr_idx] <= word_i;
      strb_r[wr_idx] <= strb_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fill_r <= '0;
    end else begin
      case ({yumi_i, accept})
        2'b11:   fill_r <= 1'b1;
        2'b10:   fill_r <= '0;
        2'b01:   fill_r <= fill_r + 1'b1;
        default: fill_r <= fill_r;
      endcase
    end
  end

  // a full beat waiting on the consumer must not move
  a_beat_held : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !yumi_i |=> valid_o && $stable(beat_o) && $stable(beat_strb_o));

endmodule

/* cache_axi_pkg.sv */
/*
 * Cache to AXI write-back definitions
 * Block, word and beat sizes, counter widths and the fixed
 * AXI write-address values that the slave side assumes.
 */

package cache_axi_pkg;

  // cache side
  localparam int NUM_CACHE   = 2;
  localparam int CACHE_ID_W  = $clog2(NUM_CACHE);
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int BLOCK_WORDS = 8;
  localparam int MASK_W      = BLOCK_WORDS;
  localparam int STRB_W      = DATA_W / 8;

  // axi side
  localparam int AXI_DATA_W     = 64;
  localparam int AXI_STRB_W     = AXI_DATA_W / 8;
  localparam int WORDS_PER_BEAT = AXI_DATA_W / DATA_W;
  localparam int BURST_LEN      = BLOCK_WORDS / WORDS_PER_BEAT;

  // pending bursts between AW acceptance and the last W beat
  localparam int TAG_DEPTH = 4;

  // counters inside the transmit block
  localparam int WORD_CNT_W = $clog2(BLOCK_WORDS);
  localparam int BEAT_CNT_W = $clog2(BURST_LEN);

  // fixed address-channel fields, not driven as ports
  // awlen is BURST_LEN-1, awid and awlock are zero
  localparam logic [1:0] AXI_BURST_INCR       = 2'b01;
  localparam logic [2:0] AXI_SIZE_8B          = 3'b011;
  localparam logic [3:0] AXI_CACHE_NONBUF     = 4'b0000;
  localparam logic [2:0] AXI_PROT_DATA_UNPRIV = 3'b000;

endpackage

/* cache_to_axi_tx.sv */
/*
 * Cache to AXI write transmitter
 * Issues one AW beat per block request and queues its cache id and
 * mask. Pulls the head cache's words, packs them into 64-bit beats
 * with strobes from the mask, and marks the last beat with wlast.
 */

`timescale 1ns/1ps

module cache_to_axi_tx
  import cache_axi_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  input  logic                             v_i,
  output logic                             yumi_o,
  input  logic [CACHE_ID_W-1:0]            cache_id_i,
  input  logic [ADDR_W-1:0]                addr_i,
  input  logic [MASK_W-1:0]                mask_i,

  // cache dma write ports
  input  logic [NUM_CACHE-1:0][DATA_W-1:0] dma_data_i,
  input  logic [NUM_CACHE-1:0]             dma_data_v_i,
  output logic [NUM_CACHE-1:0]             dma_data_yumi_o,

  // axi write address
  output logic [ADDR_W-1:0]                axi_awaddr_o,
  output logic [CACHE_ID_W-1:0]            axi_awcache_id_o,
  output logic                             axi_awvalid_o,
  input  logic                             axi_awready_i,

  // axi write data
  output logic [AXI_DATA_W-1:0]            axi_wdata_o,
  output logic [AXI_STRB_W-1:0]            axi_wstrb_o,
  output logic                             axi_wlast_o,
  output logic                             axi_wvalid_o,
  input  logic                             axi_wready_i
);

  logic                         tag_ready;
  logic                         tag_valid;
  logic                         tag_pop;
  logic [CACHE_ID_W+MASK_W-1:0] tag_data;
  logic [CACHE_ID_W-1:0]        head_id;
  logic [MASK_W-1:0]            head_mask;

  logic                         pk_valid_in;
  logic                         pk_ready;
  logic [STRB_W-1:0]            word_strb;
  logic                         word_take;
  logic                         w_fire;

  logic [WORD_CNT_W-1:0]        word_cnt_r;
  logic [BEAT_CNT_W-1:0]        beat_cnt_r;

  // request accepted together with the AW beat
  assign yumi_o           = v_i && axi_awready_i && tag_ready;
  assign axi_awvalid_o    = v_i && tag_ready;
  assign axi_awaddr_o     = addr_i;
  assign axi_awcache_id_o = cache_id_i;

  tag_fifo #(
    .WIDTH (CACHE_ID_W + MASK_W),
    .DEPTH (TAG_DEPTH)
  ) u_tag_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (yumi_o),
    .data_i  ({cache_id_i, mask_i}),
    .ready_o (tag_ready),
    .valid_o (tag_valid),
    .data_o  (tag_data),
    .pop_i   (tag_pop)
  );

  assign {head_id, head_mask} = tag_data;

  // words come only from the cache at the queue head
  assign pk_valid_in     = tag_valid && dma_data_v_i[head_id];
  assign word_take       = pk_valid_in && pk_ready;
  assign dma_data_yumi_o = word_take ? (NUM_CACHE'(1) << head_id) : '0;
  assign word_strb       = {STRB_W{head_mask[word_cnt_r]}};
  assign tag_pop         = word_take && (word_cnt_r == WORD_CNT_W'(BLOCK_WORDS - 1));

  beat_packer u_beat_packer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (pk_valid_in),
    .word_i      (dma_data_i[head_id]),
    .strb_i      (word_strb),
    .ready_o     (pk_ready),
    .valid_o     (axi_wvalid_o),
    .beat_o      (axi_wdata_o),
    .beat_strb_o (axi_wstrb_o),
    .yumi_i      (w_fire)
  );

  assign w_fire      = axi_wvalid_o && axi_wready_i;
  assign axi_wlast_o = axi_wvalid_o && (beat_cnt_r == BEAT_CNT_W'(BURST_LEN - 1));

  // word and beat position inside the current block
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      word_cnt_r <= '0;
      beat_cnt_r <= '0;
    end else begin
      if (tag_pop) begin
        word_cnt_r <= '0;
      end else if (word_take) begin
        word_cnt_r <= word_cnt_r + 1'b1;
      end
      if (w_fire) begin
        beat_cnt_r <= axi_wlast_o ? '0 : beat_cnt_r + 1'b1;
      end
    end
  end

  a_wvalid_held : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axi_wvalid_o && !axi_wready_i |=> axi_wvalid_o);

  // relies on the arbiter holding its request until yumi
  a_awvalid_held : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axi_awvalid_o && !axi_awready_i |=> axi_awvalid_o);

endmodule

/* cache_to_axi_wr.sv */
/*
 * Cache to AXI write-back path, top level
 * Round-robin arbiter over the cache write requests feeding
 * the AXI write-address and write-data transmitter.
 */

`timescale 1ns/1ps

module cache_to_axi_wr
  import cache_axi_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  // per-cache write requests
  input  logic [NUM_CACHE-1:0]             req_v_i,
  input  logic [NUM_CACHE-1:0][ADDR_W-1:0] req_addr_i,
  input  logic [NUM_CACHE-1:0][MASK_W-1:0] req_mask_i,
  output logic [NUM_CACHE-1:0]             req_yumi_o,

  // per-cache dma data
  input  logic [NUM_CACHE-1:0][DATA_W-1:0] dma_data_i,
  input  logic [NUM_CACHE-1:0]             dma_data_v_i,
  output logic [NUM_CACHE-1:0]             dma_data_yumi_o,

  // axi write address
  output logic [ADDR_W-1:0]                axi_awaddr_o,
  output logic [CACHE_ID_W-1:0]            axi_awcache_id_o,
  output logic                             axi_awvalid_o,
  input  logic                             axi_awready_i,

  // axi write data
  output logic [AXI_DATA_W-1:0]            axi_wdata_o,
  output logic [AXI_STRB_W-1:0]            axi_wstrb_o,
  output logic                             axi_wlast_o,
  output logic                             axi_wvalid_o,
  input  logic                             axi_wready_i
);

  logic                  arb_v;
  logic [CACHE_ID_W-1:0] arb_cache_id;
  logic [ADDR_W-1:0]     arb_addr;
  logic [MASK_W-1:0]     arb_mask;
  logic                  arb_yumi;

  wr_req_arbiter u_arbiter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_v_i    (req_v_i),
    .req_addr_i (req_addr_i),
    .req_mask_i (req_mask_i),
    .req_yumi_o (req_yumi_o),
    .v_o        (arb_v),
    .cache_id_o (arb_cache_id),
    .addr_o     (arb_addr),
    .mask_o     (arb_mask),
    .yumi_i     (arb_yumi)
  );

  cache_to_axi_tx u_tx (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .v_i              (arb_v),
    .yumi_o           (arb_yumi),
    .cache_id_i       (arb_cache_id),
    .addr_i           (arb_addr),
    .mask_i           (arb_mask),
    .dma_data_i       (dma_data_i),
    .dma_data_v_i     (dma_data_v_i),
    .dma_data_yumi_o  (dma_data_yumi_o),
    .axi_awaddr_o     (axi_awaddr_o),
    .axi_awcache_id_o (axi_awcache_id_o),
    .axi_awvalid_o    (axi_awvalid_o),
    .axi_awready_i    (axi_awready_i),
    .axi_wdata_o      (axi_wdata_o),
    .axi_wstrb_o      (axi_wstrb_o),
    .axi_wlast_o      (axi_wlast_o),
    .axi_wvalid_o     (axi_wvalid_o),
    .axi_wready_i     (axi_wready_i)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# compile with verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal --top-module tb_cache_to_axi_wr \
  -f sources.f -o tb_sim \
  && ./obj_dir/tb_sim | grep -qx "sim passed" \
  && echo "simulation ok" \
  || { echo "simulation not ok"; exit 1; }

/* sources.f */
cache_axi_pkg.sv
tag_fifo.sv
wr_req_arbiter.sv
beat_packer.sv
cache_to_axi_tx.sv
cache_to_axi_wr.sv
tb_cache_to_axi_wr.sv

/* tag_fifo.sv */
/*
 * Tag queue
 * Small circular register FIFO holding one tag per pending burst.
 * Push needs ready_o, pop needs valid_o.
 */

`timescale 1ns/1ps

module tag_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             ready_o,
  output logic             valid_o,
  output logic [WIDTH-1:0] data_o,
  input  logic             pop_i
);

  logic [WIDTH-1:0]           mem_r [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr_r;
  logic [$clog2(DEPTH)-1:0]   rd_ptr_r;
  logic [$clog2(DEPTH+1)-1:0] count_r;

  function automatic logic [$clog2(DEPTH)-1:0] ptr_inc(input logic [$clog2(DEPTH)-1:0] ptr);
    return (ptr == DEPTH - 1) ? '0 : ptr + 1'b1;
  endfunction

  assign ready_o = (count_r < DEPTH);
  assign valid_o = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];

  // tag storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_r <= ptr_inc(wr_ptr_r);
      end
      if (pop_i) begin
        rd_ptr_r <= ptr_inc(rd_ptr_r);
      end
      // simultaneous push and pop keeps the count
      case ({push_i, pop_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> ready_o);

  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> valid_o);

endmodule

/* tb_cache_to_axi_wr.sv */
/*
 * Testbench for the cache to AXI write-back path
 * Cache request and DMA models feed the DUT, and an AXI slave model
 * checks every AW beat and W beat against the expected block data.
 */

`timescale 1ns/1ps

module tb_cache_to_axi_wr
  import cache_axi_pkg::*;
();

  localparam int TOTAL_BLOCKS   = 20;
  localparam int RESET_CYCLES   = 16;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_BLOCKS + RESET_CYCLES;
  localparam int MAX_REQ        = 16;

  logic                             clk;
  logic                             rst_n;
  logic [NUM_CACHE-1:0]             req_v;
  logic [NUM_CACHE-1:0][ADDR_W-1:0] req_addr;
  logic [NUM_CACHE-1:0][MASK_W-1:0] req_mask;
  logic [NUM_CACHE-1:0]             req_yumi;
  logic [NUM_CACHE-1:0][DATA_W-1:0] dma_data;
  logic [NUM_CACHE-1:0]             dma_v;
  logic [NUM_CACHE-1:0]             dma_yumi;
  logic [ADDR_W-1:0]                awaddr;
  logic [CACHE_ID_W-1:0]            awcache_id;
  logic                             awvalid;
  logic                             awready;
  logic [AXI_DATA_W-1:0]            wdata;
  logic [AXI_STRB_W-1:0]            wstrb;
  logic                             wlast;
  logic                             wvalid;
  logic                             wready;

  // cache models, one request list per cache
  logic [ADDR_W-1:0] rq_addr [NUM_CACHE][MAX_REQ];
  logic [MASK_W-1:0] rq_mask [NUM_CACHE][MAX_REQ];
  int                rq_head [NUM_CACHE];
  int                rq_tail [NUM_CACHE];
  int                dma_req [NUM_CACHE];
  int                dma_word [NUM_CACHE];

  // slave model state
  int                aw_cache_q[$];
  int                aw_req_q[$];
  int                aw_log[$];
  int                beat_idx;
  int                max_in_flight;
  int                cycle_cnt;
  logic              stall_en;
  logic [15:0]       lfsr_r;
  logic              hold_aw;
  logic              hold_w;
  logic [ADDR_W-1:0] held_awaddr;
  logic [CACHE_ID_W-1:0] held_awid;
  logic [AXI_DATA_W-1:0] held_wdata;
  logic [AXI_STRB_W-1:0] held_wstrb;
  logic              held_wlast;

  cache_to_axi_wr UUT (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .req_v_i          (req_v),
    .req_addr_i       (req_addr),
    .req_mask_i       (req_mask),
    .req_yumi_o       (req_yumi),
    .dma_data_i       (dma_data),
    .dma_data_v_i     (dma_v),
    .dma_data_yumi_o  (dma_yumi),
    .axi_awaddr_o     (awaddr),
    .axi_awcache_id_o (awcache_id),
    .axi_awvalid_o    (awvalid),
    .axi_awready_i    (awready),
    .axi_wdata_o      (wdata),
    .axi_wstrb_o      (wstrb),
    .axi_wlast_o      (wlast),
    .axi_wvalid_o     (wvalid),
    .axi_wready_i     (wready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_failure("timeout, the tests did not finish in the expected number of cycles");
    end
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_r[15] ^ lfsr_r[13] ^ lfsr_r[12] ^ lfsr_r[10];
    lfsr_r = {lfsr_r[14:0], fb};
    return fb;
  endfunction

  // cache id, request number and word index in one word
  function automatic logic [DATA_W-1:0] word_value(input int c, input int r, input int w);
    return {8'hca, 4'(c), 12'(r), 8'(w)};
  endfunction

  task automatic add_request(input int c, input logic [ADDR_W-1:0] addr,
                             input logic [MASK_W-1:0] mask);
    rq_addr[c][rq_tail[c]] = addr;
    rq_mask[c][rq_tail[c]] = mask;
    rq_tail[c]++;
  endtask

  task automatic drive_inputs();
    for (int c = 0; c < NUM_CACHE; c++) begin
      req_v[c]    = rq_head[c] < rq_tail[c];
      req_addr[c] = rq_addr[c][rq_head[c] % MAX_REQ];
      req_mask[c] = rq_mask[c][rq_head[c] % MAX_REQ];
      dma_data[c] = word_value(c, dma_req[c], dma_word[c]);
      // words only for blocks whose AW beat went out
      dma_v[c]    = (dma_req[c] < rq_head[c]) && (!stall_en || lfsr_bit());
    end
    awready = !stall_en || lfsr_bit();
    wready  = !stall_en || lfsr_bit();
  endtask

  task automatic sample_and_check();
    logic [AXI_DATA_W-1:0] exp_data;
    logic [AXI_STRB_W-1:0] exp_strb;
    int c;
    int r;
    // beats stalled last cycle must be unchanged
    if (hold_aw) begin
      check_eq("axi_awvalid_o", 64'(awvalid), 64'd1);
      check_eq("axi_awaddr_o", 64'(awaddr), 64'(held_awaddr));
      check_eq("axi_awcache_id_o", 64'(awcache_id), 64'(held_awid));
    end
    if (hold_w) begin
      check_eq("axi_wvalid_o", 64'(wvalid), 64'd1);
      check_eq("axi_wdata_o", wdata, held_wdata);
      check_eq("axi_wstrb_o", 64'(wstrb), 64'(held_wstrb));
      check_eq("axi_wlast_o", 64'(wlast), 64'(held_wlast));
    end
    hold_aw     = awvalid && !awready;
    held_awaddr = awaddr;
    held_awid   = awcache_id;
    hold_w      = wvalid && !wready;
    held_wdata  = wdata;
    held_wstrb  = wstrb;
    held_wlast  = wlast;
    // grant pulses together with the AW beat
    check_eq("req_yumi_o", 64'(req_yumi), (awvalid && awready) ? (64'd1 << awcache_id) : 64'd0);
    if (awvalid && awready) begin
      c = int'(awcache_id);
      if (rq_head[c] >= rq_tail[c]) begin
        report_failure("write address issued for a cache that has no pending request");
      end
      check_eq("axi_awaddr_o", 64'(awaddr), 64'(rq_addr[c][rq_head[c]]));
      aw_cache_q.push_back(c);
      aw_req_q.push_back(rq_head[c]);
      aw_log.push_back(c);
      rq_head[c]++;
      if (aw_cache_q.size() > max_in_flight) begin
        max_in_flight = aw_cache_q.size();
      end
    end
    for (int i = 0; i < NUM_CACHE; i++) begin
      if (dma_yumi[i] && !dma_v[i]) begin
        report_failure("a DMA word was taken while the cache offered none");
      end
      if (dma_yumi[i]) begin
        dma_word[i]++;
        if (dma_word[i] == BLOCK_WORDS) begin
          dma_word[i] = 0;
          dma_req[i]++;
        end
      end
    end
    if (wvalid && wready) begin
      if (aw_cache_q.size() == 0) begin
        report_failure("a write data beat arrived with no pending write address");
      end
      c = aw_cache_q[0];
      r = aw_req_q[0];
      // word 2k low, word 2k+1 high, four strobes per mask bit
      for (int j = 0; j < WORDS_PER_BEAT; j++) begin
        exp_data[j*DATA_W +: DATA_W] = word_value(c, r, beat_idx * WORDS_PER_BEAT + j);
        exp_strb[j*STRB_W +: STRB_W] = {STRB_W{rq_mask[c][r][beat_idx * WORDS_PER_BEAT + j]}};
      end
      check_eq("axi_wdata_o", wdata, exp_data);
      check_eq("axi_wstrb_o", 64'(wstrb), 64'(exp_strb));
      check_eq("axi_wlast_o", 64'(wlast), 64'(beat_idx == BURST_LEN - 1));
      beat_idx++;
      if (beat_idx == BURST_LEN) begin
        beat_idx = 0;
        void'(aw_cache_q.pop_front());
        void'(aw_req_q.pop_front());
      end
    end
  endtask

  task automatic cycle_step();
    @(negedge clk);
    drive_inputs();
    #1;
    sample_and_check();
  endtask

  task automatic run_until_idle();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      cycle_step();
      busy = aw_cache_q.size() != 0;
      for (int c = 0; c < NUM_CACHE; c++) begin
        if (rq_head[c] != rq_tail[c] || dma_req[c] != rq_tail[c]) begin
          busy = 1'b1;
        end
      end
    end
  endtask

  task automatic idle_outputs_low();
    repeat (20) begin
      cycle_step();
      check_eq("axi_awvalid_o", 64'(awvalid), 64'd0);
      check_eq("axi_wvalid_o", 64'(wvalid), 64'd0);
      check_eq("req_yumi_o", 64'(req_yumi), 64'd0);
      check_eq("dma_data_yumi_o", 64'(dma_yumi), 64'd0);
    end
  endtask

  task automatic single_block(input int c, input logic [ADDR_W-1:0] addr,
                              input logic [MASK_W-1:0] mask);
    add_request(c, addr, mask);
    run_until_idle();
  endtask

  task automatic round_robin_pair();
    aw_log.delete();
    for (int n = 0; n < 3; n++) begin
      add_request(0, 32'h0001_0000 + 32'(n * 64), 8'hff);
      add_request(1, 32'h0002_0000 + 32'(n * 64), 8'h3c);
    end
    run_until_idle();
    // both always requesting, so grants alternate
    for (int i = 1; i < aw_log.size(); i++) begin
      check_eq("axi_awcache_id_o", 64'(aw_log[i]), 64'((aw_log[i-1] + 1) % NUM_CACHE));
    end
  endtask

  task automatic stalled_traffic();
    logic [MASK_W-1:0] m;
    max_in_flight = 0;
    stall_en      = 1'b1;
    for (int n = 0; n < 6; n++) begin
      for (int c = 0; c < NUM_CACHE; c++) begin
        for (int b = 0; b < MASK_W; b++) begin
          m[b] = lfsr_bit();
        end
        add_request(c, 32'h0010_0000 + 32'(c * 4096 + n * 64), m);
      end
    end
    run_until_idle();
    stall_en = 1'b0;
    if (max_in_flight < 2) begin
      report_failure("stalled traffic never had more than one burst in flight");
    end
  endtask

  initial begin
    rst_n    = 1'b0;
    req_v    = '0;
    req_addr = '0;
    req_mask = '0;
    dma_data = '0;
    dma_v    = '0;
    awready  = 1'b0;
    wready   = 1'b0;
    for (int c = 0; c < NUM_CACHE; c++) begin
      rq_head[c]  = 0;
      rq_tail[c]  = 0;
      dma_req[c]  = 0;
      dma_word[c] = 0;
    end
    beat_idx      = 0;
    max_in_flight = 0;
    cycle_cnt     = 0;
    stall_en      = 1'b0;
    hold_aw       = 1'b0;
    hold_w        = 1'b0;
    lfsr_r        = 16'd30488;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    idle_outputs_low();
    single_block(0, 32'h0000_1000, 8'hff);
    single_block(0, 32'h0000_2040, 8'ha5);
    round_robin_pair();
    stalled_traffic();
    $display("sim passed");
    $finish;
  end

endmodule

/* wr_req_arbiter.sv */
/*
 * Write request arbiter
 * Round-robin choice among the cache write requests. The winner's
 * address and mask go to the transmit block; its grant pulses on yumi.
 */

`timescale 1ns/1ps

module wr_req_arbiter
  import cache_axi_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [NUM_CACHE-1:0]              req_v_i,
  input  logic [NUM_CACHE-1:0][ADDR_W-1:0]  req_addr_i,
  input  logic [NUM_CACHE-1:0][MASK_W-1:0]  req_mask_i,
  output logic [NUM_CACHE-1:0]              req_yumi_o,
  output logic                              v_o,
  output logic [CACHE_ID_W-1:0]             cache_id_o,
  output logic [ADDR_W-1:0]                 addr_o,
  output logic [MASK_W-1:0]                 mask_o,
  input  logic                              yumi_i
);

  logic [CACHE_ID_W-1:0] ptr_r;
  logic                  lock_r;
  logic [CACHE_ID_W-1:0] lock_id_r;
  logic                  found;
  logic [CACHE_ID_W-1:0] pick_id;

  // first valid request at or after the pointer
  always_comb begin
    found   = 1'b0;
    pick_id = ptr_r;
    for (int i = 0; i < NUM_CACHE; i++) begin
      if (!found && req_v_i[(int'(ptr_r) + i) % NUM_CACHE]) begin
        found   = 1'b1;
        pick_id = CACHE_ID_W'((int'(ptr_r) + i) % NUM_CACHE);
      end
    end
  end

  // a presented but unaccepted request keeps its grant, so awaddr holds
  assign cache_id_o = lock_r ? lock_id_r : pick_id;
  assign v_o        = lock_r ? req_v_i[lock_id_r] : found;
  assign addr_o     = req_addr_i[cache_id_o];
  assign mask_o     = req_mask_i[cache_id_o];
  assign req_yumi_o = yumi_i ? (NUM_CACHE'(1) << cache_id_o) : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_r     <= '0;
      lock_r    <= 1'b0;
      lock_id_r <= '0;
    end else if (yumi_i) begin
      // move priority past the winner
      ptr_r  <= (cache_id_o == CACHE_ID_W'(NUM_CACHE - 1)) ? '0 : cache_id_o + 1'b1;
      lock_r <= 1'b0;
    end else if (v_o) begin
      lock_r    <= 1'b1;
      lock_id_r <= cache_id_o;
    end
  end

  a_yumi_needs_v : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    yumi_i |-> v_o);

endmodule
